// ==== verilog/llc_pkg.sv ====
// LLC shared sizes and types
// Address split, payloads and line state

package llc_pkg;

    // Cache geometry
    localparam int LLC_WAYS   = 4;
    localparam int LLC_SETS   = 16;
    localparam int LINE_WORDS = 4;
    localparam int WORD_BITS  = 32;
    localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;

    // Line address split, set in the low bits
    localparam int ADDR_BITS = 16;
    localparam int SET_BITS  = 4;
    localparam int TAG_BITS  = 12;
    localparam int WAY_BITS  = 2;

    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]  llc_set_t;
    typedef logic [TAG_BITS-1:0]  llc_tag_t;
    typedef logic [WAY_BITS-1:0]  llc_way_t;
    typedef logic [LINE_BITS-1:0] line_t;

    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } llc_state_t;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } llc_op_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

    // Requester to cache
    typedef struct packed {
        llc_op_t    op;
        line_addr_t addr;
        line_t      line;
    } llc_req_t;

    // Memory to cache, one fill line
    typedef struct packed {
        line_t line;
    } llc_mem_rsp_t;

    // Cache to requester, line is zero for a write
    typedef struct packed {
        llc_op_t op;
        line_t   line;
    } llc_rsp_t;

endpackage

// ==== verilog/llc_chan_buf.sv ====
// One-entry channel buffer

`timescale 1ns/1ps

module llc_chan_buf #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    input  PAYLOAD_T in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output PAYLOAD_T out_data_o,
    input  logic     pop_i
);

    logic     full_q;
    logic     accept;
    PAYLOAD_T data_q;

    // A pop frees the slot for an arrival in the same cycle
    assign in_ready_o = !full_q || pop_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (pop_i) begin
            full_q <= 1'b0;
        end
    end

    // Payload is kept after a pop until the next arrival
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

// ==== verilog/llc_ctrl.sv ====
// LLC request phase sequencer

`timescale 1ns/1ps

module llc_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid_i,
    output logic req_pop_o,
    input  logic mem_rsp_valid_i,
    output logic mem_rsp_pop_o,
    input  logic hit_i,
    input  logic evict_dirty_i,
    input  logic mem_req_ready_i,
    input  logic rsp_ready_i,
    output logic rd_set_en_o,
    output logic lookup_en_o,
    output logic evict_en_o,
    output logic fill_req_en_o,
    output logic update_en_o,
    output logic respond_en_o
);

    typedef enum logic [2:0] {
        DECODE    = 3'd0,
        READ_SET  = 3'd1,
        LOOKUP    = 3'd2,
        EVICT     = 3'd3,
        FILL_REQ  = 3'd4,
        FILL_WAIT = 3'd5,
        UPDATE    = 3'd6,
        RESPOND   = 3'd7
    } phase_t;

    phase_t phase_q;
    phase_t phase_d;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase_q <= DECODE;
        end else begin
            phase_q <= phase_d;
        end
    end

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            DECODE: begin
                if (req_valid_i) begin
                    phase_d = READ_SET;
                end
            end
            READ_SET: begin
                phase_d = LOOKUP;
            end
            LOOKUP: begin
                if (hit_i) begin
                    phase_d = UPDATE;
                end else if (evict_dirty_i) begin
                    phase_d = EVICT;
                end else begin
                    phase_d = FILL_REQ;
                end
            end
            EVICT: begin
                // Write-back goes out before the fill request
                if (mem_req_ready_i) begin
                    phase_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_req_ready_i) begin
                    phase_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    phase_d = UPDATE;
                end
            end
            UPDATE: begin
                phase_d = RESPOND;
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    phase_d = DECODE;
                end
            end
            default: begin
                phase_d = DECODE;
            end
        endcase
    end

    // Channel consumption
    assign req_pop_o     = (phase_q == DECODE) && req_valid_i;
    assign mem_rsp_pop_o = (phase_q == FILL_WAIT) && mem_rsp_valid_i;

    assign rd_set_en_o   = (phase_q == READ_SET);
    assign lookup_en_o   = (phase_q == LOOKUP);
    assign evict_en_o    = (phase_q == EVICT);
    assign fill_req_en_o = (phase_q == FILL_REQ);
    assign update_en_o   = (phase_q == UPDATE);
    assign respond_en_o  = (phase_q == RESPOND);

endmodule

// ==== verilog/llc_localmem.sv ====
// LLC tag, state, dirty and line arrays
// Per-set round-robin eviction pointer

`timescale 1ns/1ps

module llc_localmem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en_i,
    input  llc_pkg::llc_set_t      set_i,
    input  logic                   wr_en_i,
    input  llc_pkg::llc_way_t      wr_way_i,
    input  llc_pkg::llc_tag_t      wr_tag_i,
    input  llc_pkg::llc_state_t    wr_state_i,
    input  logic                   wr_dirty_i,
    input  llc_pkg::line_t         wr_line_i,
    input  logic                   incr_evict_i,
    output llc_pkg::llc_tag_t      rd_tag_o   [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_state_t    rd_state_o [llc_pkg::LLC_WAYS],
    output logic                   rd_dirty_o [llc_pkg::LLC_WAYS],
    output llc_pkg::line_t         rd_line_o  [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_way_t      rd_evict_way_o
);

    llc_pkg::llc_tag_t   tag_mem   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::line_t      line_mem  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_state_t state_mem [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic                dirty_mem [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_way_t   evict_ptr [llc_pkg::LLC_SETS];

    // State, dirty and pointers start cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
                for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                    state_mem[s][w] <= llc_pkg::INVALID;
                    dirty_mem[s][w] <= 1'b0;
                end
            end
        end else begin
            if (wr_en_i) begin
                state_mem[set_i][wr_way_i] <= wr_state_i;
                dirty_mem[set_i][wr_way_i] <= wr_dirty_i;
            end
            if (incr_evict_i) begin
                evict_ptr[set_i] <= evict_ptr[set_i] + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[set_i][wr_way_i]  <= wr_tag_i;
            line_mem[set_i][wr_way_i] <= wr_line_i;
        end
    end

    // Whole set read, held until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                rd_tag_o[w]   <= tag_mem[set_i][w];
                rd_state_o[w] <= state_mem[set_i][w];
                rd_dirty_o[w] <= dirty_mem[set_i][w];
                rd_line_o[w]  <= line_mem[set_i][w];
            end
            rd_evict_way_o <= evict_ptr[set_i];
        end
    end

endmodule

// ==== verilog/llc_lookup_way.sv ====
// LLC hit way and victim selection

`timescale 1ns/1ps

module llc_lookup_way (
    input  logic                clk,
    input  logic                rst,
    input  logic                en_i,
    input  llc_pkg::llc_tag_t   tag_i,
    input  llc_pkg::llc_tag_t   rd_tag_i   [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_state_t rd_state_i [llc_pkg::LLC_WAYS],
    input  logic                rd_dirty_i [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_way_t   rd_evict_way_i,
    output logic                hit_o,
    output llc_pkg::llc_way_t   way_o,
    output logic                evict_dirty_o,
    output llc_pkg::llc_tag_t   evict_tag_o
);

    logic              hit_c;
    llc_pkg::llc_way_t hit_way_c;
    llc_pkg::llc_way_t victim_c;
    logic              hit_q;
    logic              evict_dirty_q;
    llc_pkg::llc_way_t way_q;
    llc_pkg::llc_tag_t evict_tag_q;

    // Downward scan leaves the lowest invalid way as victim
    always_comb begin
        hit_c     = 1'b0;
        hit_way_c = '0;
        victim_c  = rd_evict_way_i;
        for (int w = llc_pkg::LLC_WAYS - 1; w >= 0; w--) begin
            if (rd_state_i[w] == llc_pkg::VALID && rd_tag_i[w] == tag_i) begin
                hit_c     = 1'b1;
                hit_way_c = llc_pkg::llc_way_t'(w);
            end
            if (rd_state_i[w] == llc_pkg::INVALID) begin
                victim_c = llc_pkg::llc_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_q         <= 1'b0;
            evict_dirty_q <= 1'b0;
            way_q         <= '0;
        end else if (en_i) begin
            hit_q         <= hit_c;
            evict_dirty_q <= !hit_c && rd_dirty_i[victim_c];
            way_q         <= hit_c ? hit_way_c : victim_c;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            evict_tag_q <= rd_tag_i[victim_c];
        end
    end

    // Forwarded during en so the sequencer branches out of LOOKUP
    assign hit_o         = en_i ? hit_c : hit_q;
    assign evict_dirty_o = en_i ? (!hit_c && rd_dirty_i[victim_c]) : evict_dirty_q;
    assign way_o         = en_i ? (hit_c ? hit_way_c : victim_c) : way_q;
    assign evict_tag_o   = en_i ? rd_tag_i[victim_c] : evict_tag_q;

endmodule

// ==== verilog/llc_process.sv ====
// LLC request processing
// Memory requests, array write data and response

`timescale 1ns/1ps

module llc_process (
    input  logic                clk,
    input  logic                rst,
    input  llc_pkg::llc_req_t   req_i,
    input  llc_pkg::llc_mem_rsp_t mem_rsp_i,
    input  llc_pkg::llc_way_t   way_i,
    input  logic                hit_i,
    input  llc_pkg::llc_tag_t   evict_tag_i,
    input  llc_pkg::line_t      rd_line_i [llc_pkg::LLC_WAYS],
    input  logic                evict_en_i,
    input  logic                fill_req_en_i,
    input  logic                update_en_i,
    input  logic                respond_en_i,
    output logic                mem_req_valid_o,
    output llc_pkg::mem_op_t    mem_req_op_o,
    output llc_pkg::line_addr_t mem_req_addr_o,
    output llc_pkg::line_t      mem_req_line_o,
    output logic                rsp_valid_o,
    output llc_pkg::llc_rsp_t   rsp_o,
    output logic                wr_en_o,
    output llc_pkg::llc_tag_t   wr_tag_o,
    output llc_pkg::llc_state_t wr_state_o,
    output logic                wr_dirty_o,
    output llc_pkg::line_t      wr_line_o,
    output logic                incr_evict_o
);

    llc_pkg::line_t    line_q;
    llc_pkg::llc_rsp_t rsp_q;
    llc_pkg::llc_set_t set;
    llc_pkg::llc_tag_t tag;
    logic              is_write;

    assign set      = req_i.addr[llc_pkg::SET_BITS-1:0];
    assign tag      = req_i.addr[llc_pkg::ADDR_BITS-1:llc_pkg::SET_BITS];
    assign is_write = (req_i.op == llc_pkg::REQ_WRITE);

    // Line of the selected way
    always_ff @(posedge clk) begin
        line_q <= rd_line_i[way_i];
    end

    // Victim write-back, then fill of the requested line
    assign mem_req_valid_o = evict_en_i || fill_req_en_i;
    assign mem_req_op_o    = evict_en_i ? llc_pkg::MEM_WRITE : llc_pkg::MEM_READ;
    assign mem_req_addr_o  = evict_en_i ? {evict_tag_i, set} : req_i.addr;
    assign mem_req_line_o  = evict_en_i ? line_q : '0;

    // Read hit leaves the entry as it is
    assign wr_en_o      = update_en_i && (is_write || !hit_i);
    assign wr_tag_o     = tag;
    assign wr_state_o   = llc_pkg::VALID;
    assign wr_dirty_o   = is_write;
    assign wr_line_o    = is_write ? req_i.line : mem_rsp_i.line;
    assign incr_evict_o = update_en_i && !hit_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_q <= '0;
        end else if (update_en_i) begin
            rsp_q.op <= req_i.op;
            if (is_write) begin
                rsp_q.line <= '0;
            end else if (hit_i) begin
                rsp_q.line <= line_q;
            end else begin
                rsp_q.line <= mem_rsp_i.line;
            end
        end
    end

    assign rsp_valid_o = respond_en_i;
    assign rsp_o       = rsp_q;

endmodule

// ==== verilog/llc_core.sv ====
// LLC core top level

`timescale 1ns/1ps

module llc_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  llc_pkg::llc_req_t     req_i,
    output logic                  req_ready_o,
    input  logic                  mem_rsp_valid_i,
    input  llc_pkg::llc_mem_rsp_t mem_rsp_i,
    output logic                  mem_rsp_ready_o,
    output logic                  rsp_valid_o,
    output llc_pkg::llc_rsp_t     rsp_o,
    input  logic                  rsp_ready_i,
    output logic                  mem_req_valid_o,
    output llc_pkg::mem_op_t      mem_req_op_o,
    output llc_pkg::line_addr_t   mem_req_addr_o,
    output llc_pkg::line_t        mem_req_line_o,
    input  logic                  mem_req_ready_i
);

    logic                  req_buf_valid;
    llc_pkg::llc_req_t     req_buf_data;
    llc_pkg::llc_req_t     req_q;
    logic                  req_pop;
    logic                  mem_rsp_buf_valid;
    llc_pkg::llc_mem_rsp_t mem_rsp_buf_data;
    logic                  mem_rsp_pop;
    logic                  hit;
    logic                  evict_dirty;
    llc_pkg::llc_way_t     way;
    llc_pkg::llc_tag_t     evict_tag;
    logic                  rd_set_en;
    logic                  lookup_en;
    logic                  evict_en;
    logic                  fill_req_en;
    logic                  update_en;
    logic                  respond_en;
    llc_pkg::llc_tag_t     rd_tag   [llc_pkg::LLC_WAYS];
    llc_pkg::llc_state_t   rd_state [llc_pkg::LLC_WAYS];
    logic                  rd_dirty [llc_pkg::LLC_WAYS];
    llc_pkg::line_t        rd_line  [llc_pkg::LLC_WAYS];
    llc_pkg::llc_way_t     rd_evict_way;
    logic                  wr_en;
    llc_pkg::llc_tag_t     wr_tag;
    llc_pkg::llc_state_t   wr_state;
    logic                  wr_dirty;
    llc_pkg::line_t        wr_line;
    logic                  incr_evict;

    llc_chan_buf #(.PAYLOAD_T(llc_pkg::llc_req_t)) req_buf (
        .clk(clk), .rst(rst),
        .in_valid_i(req_valid_i), .in_data_i(req_i), .in_ready_o(req_ready_o),
        .out_valid_o(req_buf_valid), .out_data_o(req_buf_data), .pop_i(req_pop)
    );

    llc_chan_buf #(.PAYLOAD_T(llc_pkg::llc_mem_rsp_t)) mem_rsp_buf (
        .clk(clk), .rst(rst),
        .in_valid_i(mem_rsp_valid_i), .in_data_i(mem_rsp_i), .in_ready_o(mem_rsp_ready_o),
        .out_valid_o(mem_rsp_buf_valid), .out_data_o(mem_rsp_buf_data), .pop_i(mem_rsp_pop)
    );

    // Request held for the whole transaction, the buffer refills after DECODE
    always_ff @(posedge clk) begin
        if (req_pop) begin
            req_q <= req_buf_data;
        end
    end

    llc_ctrl ctrl_u (
        .clk(clk), .rst(rst),
        .req_valid_i(req_buf_valid), .req_pop_o(req_pop),
        .mem_rsp_valid_i(mem_rsp_buf_valid), .mem_rsp_pop_o(mem_rsp_pop),
        .hit_i(hit), .evict_dirty_i(evict_dirty),
        .mem_req_ready_i(mem_req_ready_i), .rsp_ready_i(rsp_ready_i),
        .rd_set_en_o(rd_set_en), .lookup_en_o(lookup_en), .evict_en_o(evict_en),
        .fill_req_en_o(fill_req_en), .update_en_o(update_en), .respond_en_o(respond_en)
    );

    llc_localmem localmem_u (
        .clk(clk), .rst(rst),
        .rd_en_i(rd_set_en), .set_i(req_q.addr[llc_pkg::SET_BITS-1:0]),
        .wr_en_i(wr_en), .wr_way_i(way), .wr_tag_i(wr_tag), .wr_state_i(wr_state),
        .wr_dirty_i(wr_dirty), .wr_line_i(wr_line), .incr_evict_i(incr_evict),
        .rd_tag_o(rd_tag), .rd_state_o(rd_state), .rd_dirty_o(rd_dirty),
        .rd_line_o(rd_line), .rd_evict_way_o(rd_evict_way)
    );

    llc_lookup_way lookup_way_u (
        .clk(clk), .rst(rst), .en_i(lookup_en),
        .tag_i(req_q.addr[llc_pkg::ADDR_BITS-1:llc_pkg::SET_BITS]),
        .rd_tag_i(rd_tag), .rd_state_i(rd_state), .rd_dirty_i(rd_dirty),
        .rd_evict_way_i(rd_evict_way),
        .hit_o(hit), .way_o(way), .evict_dirty_o(evict_dirty), .evict_tag_o(evict_tag)
    );

    llc_process process_u (
        .clk(clk), .rst(rst),
        .req_i(req_q), .mem_rsp_i(mem_rsp_buf_data),
        .way_i(way), .hit_i(hit), .evict_tag_i(evict_tag), .rd_line_i(rd_line),
        .evict_en_i(evict_en), .fill_req_en_i(fill_req_en),
        .update_en_i(update_en), .respond_en_i(respond_en),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_op_o(mem_req_op_o),
        .mem_req_addr_o(mem_req_addr_o), .mem_req_line_o(mem_req_line_o),
        .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
        .wr_en_o(wr_en), .wr_tag_o(wr_tag), .wr_state_o(wr_state),
        .wr_dirty_o(wr_dirty), .wr_line_o(wr_line), .incr_evict_o(incr_evict)
    );

endmodule

// ==== sim/llc_tb_clk.sv ====
// Testbench clock source

`timescale 1ns/1ps

module llc_tb_clk (
    output logic clk_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

endmodule

// ==== sim/llc_core_assert.sv ====
// LLC core output channel assertions

`timescale 1ns/1ps

module llc_core_assert (
    input logic                clk,
    input logic                rst,
    input logic                rsp_valid_i,
    input llc_pkg::llc_rsp_t   rsp_i,
    input logic                rsp_ready_i,
    input logic                mem_req_valid_i,
    input llc_pkg::mem_op_t    mem_req_op_i,
    input llc_pkg::line_addr_t mem_req_addr_i,
    input llc_pkg::line_t      mem_req_line_i,
    input logic                mem_req_ready_i
);

    rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else $error("rsp payload changed while stalled");

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_op_i)
            && $stable(mem_req_addr_i) && $stable(mem_req_line_i))
        else $error("mem_req payload changed while stalled");

    one_output: assert property (@(posedge clk) disable iff (!rst)
        !(rsp_valid_i && mem_req_valid_i))
        else $error("rsp and mem_req valid together");

    quiet_in_reset: assert property (@(posedge clk)
        !rst |-> !rsp_valid_i && !mem_req_valid_i)
        else $error("output valid during reset");

endmodule

bind llc_core llc_core_assert core_assert_u (
    .clk(clk), .rst(rst),
    .rsp_valid_i(rsp_valid_o), .rsp_i(rsp_o), .rsp_ready_i(rsp_ready_i),
    .mem_req_valid_i(mem_req_valid_o), .mem_req_op_i(mem_req_op_o),
    .mem_req_addr_i(mem_req_addr_o), .mem_req_line_i(mem_req_line_o),
    .mem_req_ready_i(mem_req_ready_i)
);

// ==== sim/llc_tb.sv ====
// LLC core testbench

`timescale 1ns/1ps

module llc_tb;

    localparam int NUM_REQS   = 400;
    localparam int MAX_CYCLES = NUM_REQS * 60 + 200;
    // Accepting edge plus four more edges until rsp valid
    localparam int HIT_EDGES  = 4;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    llc_pkg::llc_req_t     req;
    logic                  req_ready;
    logic                  mem_rsp_valid;
    llc_pkg::llc_mem_rsp_t mem_rsp;
    logic                  mem_rsp_ready;
    logic                  rsp_valid;
    llc_pkg::llc_rsp_t     rsp;
    logic                  rsp_ready;
    logic                  mem_req_valid;
    llc_pkg::mem_op_t      mem_req_op;
    llc_pkg::line_addr_t   mem_req_addr;
    llc_pkg::line_t        mem_req_line;
    logic                  mem_req_ready;

    int value_errs = 0;
    int other_errs = 0;
    int cyc = 0;
    int rsp_count = 0;
    int rsp_cyc = 0;
    int accept_cyc = 0;
    int fill_delay = 0;
    logic hold_ready = 1'b0;
    logic mem_rsp_fire = 1'b0;
    logic [31:0] drv_seed = 32'h626c6818;
    logic [31:0] chan_seed = 32'h626c6818 ^ 32'hffff0000;

    // Reference model state
    llc_pkg::llc_tag_t m_tag   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::line_t    m_line  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic              m_valid [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic              m_dirty [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_way_t m_ptr   [llc_pkg::LLC_SETS];
    llc_pkg::line_t    golden  [llc_pkg::line_addr_t];
    llc_pkg::line_t    m_mem   [llc_pkg::line_addr_t];
    llc_pkg::line_t    tb_mem  [llc_pkg::line_addr_t];

    llc_pkg::mem_op_t    exp_mem_op   [$];
    llc_pkg::line_addr_t exp_mem_addr [$];
    llc_pkg::line_t      exp_mem_line [$];
    llc_pkg::llc_op_t    exp_rsp_op   [$];
    llc_pkg::line_t      exp_rsp_line [$];
    llc_pkg::line_t      fill_q       [$];

    llc_tb_clk clk_gen (.clk_o(clk));

    llc_core dut0 (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
        .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_i(mem_rsp), .mem_rsp_ready_o(mem_rsp_ready),
        .rsp_valid_o(rsp_valid), .rsp_o(rsp), .rsp_ready_i(rsp_ready),
        .mem_req_valid_o(mem_req_valid), .mem_req_op_o(mem_req_op),
        .mem_req_addr_o(mem_req_addr), .mem_req_line_o(mem_req_line),
        .mem_req_ready_i(mem_req_ready)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten memory, every word mixes the full line address
    function automatic llc_pkg::line_t pattern_line(input llc_pkg::line_addr_t a);
        llc_pkg::line_t l;
        for (int i = 0; i < llc_pkg::LINE_WORDS; i++) begin
            l[i*32 +: 32] = {a, 8'h5c, 6'h0, 2'(i)} ^ 32'h9e3779b9;
        end
        return l;
    endfunction

    // 48 lines, 12 tags on each of 4 sets
    function automatic llc_pkg::line_addr_t pool_addr(input int k);
        llc_pkg::llc_set_t s;
        case (k % 4)
            0: s = 4'd2;
            1: s = 4'd7;
            2: s = 4'd11;
            default: s = 4'd13;
        endcase
        return {12'(k / 4 + 'h3a0), s};
    endfunction

    task automatic check_line(input string name, input llc_pkg::line_t got,
                              input llc_pkg::line_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_addr(input string name, input llc_pkg::line_addr_t got,
                              input llc_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_op(input string name, input llc_pkg::mem_op_t got,
                            input llc_pkg::mem_op_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_req_op(input string name, input llc_pkg::llc_op_t got,
                                input llc_pkg::llc_op_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    // Follows the cache for one request and queues the expected traffic
    task automatic model_request(input llc_pkg::llc_op_t op, input llc_pkg::line_addr_t a,
                                 input llc_pkg::line_t l);
        llc_pkg::llc_set_t s;
        llc_pkg::llc_tag_t t;
        llc_pkg::llc_way_t way;
        llc_pkg::line_addr_t va;
        logic hit;
        s = a[3:0];
        t = a[15:4];
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = m_ptr[s];
            for (int w = llc_pkg::LLC_WAYS - 1; w >= 0; w--) begin
                if (!m_valid[s][w]) begin
                    way = 2'(w);
                end
            end
            if (m_valid[s][way] && m_dirty[s][way]) begin
                va = {m_tag[s][way], s};
                exp_mem_op.push_back(llc_pkg::MEM_WRITE);
                exp_mem_addr.push_back(va);
                exp_mem_line.push_back(m_line[s][way]);
                m_mem[va] = m_line[s][way];
            end
            exp_mem_op.push_back(llc_pkg::MEM_READ);
            exp_mem_addr.push_back(a);
            exp_mem_line.push_back('0);
            m_ptr[s] = m_ptr[s] + 2'd1;
            m_valid[s][way] = 1'b1;
            m_tag[s][way] = t;
            m_dirty[s][way] = 1'b0;
            m_line[s][way] = m_mem.exists(a) ? m_mem[a] : pattern_line(a);
        end
        exp_rsp_op.push_back(op);
        if (op == llc_pkg::REQ_WRITE) begin
            m_line[s][way] = l;
            m_dirty[s][way] = 1'b1;
            golden[a] = l;
            exp_rsp_line.push_back('0);
        end else begin
            exp_rsp_line.push_back(golden.exists(a) ? golden[a] : pattern_line(a));
        end
    endtask

    // Called at a falling edge, returns at the falling edge after acceptance
    task automatic send_request(input llc_pkg::llc_op_t op, input llc_pkg::line_addr_t a,
                                input llc_pkg::line_t l);
        model_request(op, a, l);
        req_valid = 1'b1;
        req.op = op;
        req.addr = a;
        req.line = l;
        while (!req_ready) begin
            @(negedge clk);
        end
        accept_cyc = cyc + 1;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cyc);
            $display("Something failed");
            $finish;
        end
    end

    // Ready toggling, memory model and response checks
    always @(negedge clk) begin
        chan_seed = lcg(chan_seed);
        rsp_ready = hold_ready || (chan_seed[29:28] != 2'd0);
        mem_req_ready = hold_ready || (chan_seed[27:26] != 2'd0);
        if (mem_rsp_fire) begin
            mem_rsp_valid = 1'b0;
        end
        if (!mem_rsp_valid && fill_q.size() > 0) begin
            if (fill_delay > 0) begin
                fill_delay--;
            end else begin
                mem_rsp_valid = 1'b1;
                mem_rsp.line = fill_q.pop_front();
            end
        end
        if (mem_req_valid && mem_req_ready) begin
            if (exp_mem_op.size() == 0) begin
                $display("Memory request at %0t that the model did not predict", $time);
                other_errs++;
            end else begin
                check_op("mem_req_op", mem_req_op, exp_mem_op.pop_front());
                check_addr("mem_req_addr", mem_req_addr, exp_mem_addr.pop_front());
                if (mem_req_op == llc_pkg::MEM_WRITE) begin
                    check_line("mem_req_line", mem_req_line, exp_mem_line.pop_front());
                    tb_mem[mem_req_addr] = mem_req_line;
                end else begin
                    void'(exp_mem_line.pop_front());
                    fill_q.push_back(tb_mem.exists(mem_req_addr) ?
                                     tb_mem[mem_req_addr] : pattern_line(mem_req_addr));
                    fill_delay = 32'(chan_seed[23:16]) % 6;
                end
            end
        end
        mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;
        if (rsp_valid && rsp_ready) begin
            if (exp_rsp_op.size() == 0) begin
                $display("Response at %0t with no request outstanding", $time);
                other_errs++;
            end else begin
                check_req_op("rsp_op", rsp.op, exp_rsp_op.pop_front());
                check_line("rsp_line", rsp.line, exp_rsp_line.pop_front());
            end
            rsp_count++;
            rsp_cyc = cyc;
        end
    end

    initial begin
        llc_pkg::line_t l;
        llc_pkg::line_addr_t a;
        llc_pkg::llc_op_t op;
        rst = 1'b0;
        req_valid = 1'b0;
        req = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
            m_ptr[s] = '0;
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_line[s][w] = '0;
            end
        end
        repeat (5) @(negedge clk);
        rst = 1'b1;
        for (int n = 0; n < NUM_REQS; n++) begin
            drv_seed = lcg(drv_seed);
            repeat (32'(drv_seed[31:30]) % 3) @(negedge clk);
            op = llc_pkg::llc_op_t'(drv_seed[20]);
            a = pool_addr(32'(drv_seed[27:22]) % 48);
            for (int i = 0; i < llc_pkg::LINE_WORDS; i++) begin
                drv_seed = lcg(drv_seed);
                l[i*32 +: 32] = drv_seed;
            end
            send_request(op, a, l);
        end
        wait (rsp_count == NUM_REQS);

        // Hit latency of a read right after a write to the same line
        hold_ready = 1'b1;
        @(negedge clk);
        a = pool_addr(5);
        send_request(llc_pkg::REQ_WRITE, a, {4{32'hc0ffe17e}});
        wait (rsp_count == NUM_REQS + 1);
        @(negedge clk);
        send_request(llc_pkg::REQ_READ, a, '0);
        wait (rsp_count == NUM_REQS + 2);
        if (rsp_cyc - accept_cyc != HIT_EDGES) begin
            $display("FAILED at %0t: hit latency got %0d expected %0d", $time,
                     rsp_cyc - accept_cyc, HIT_EDGES);
            value_errs++;
        end
        repeat (4) @(negedge clk);
        if (exp_mem_op.size() != 0 || exp_rsp_op.size() != 0 || fill_q.size() != 0) begin
            $display("Predicted traffic left over at the end of the run");
            other_errs++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/llc_pkg.sv
verilog/llc_chan_buf.sv
verilog/llc_ctrl.sv
verilog/llc_localmem.sv
verilog/llc_lookup_way.sv
verilog/llc_process.sv
verilog/llc_core.sv
sim/llc_tb_clk.sv
sim/llc_core_assert.sv
sim/llc_tb.sv

// ==== Makefile ====
TOP := llc_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
